/* Bender.yml */
package:
  name: box_overlay

sources:
  - box_overlay_pkg.sv
  - video_if.sv
  - box_if.sv
  - video_timing_gen.sv
  - box_table.sv
  - box_overlay.sv
  - box_overlay_top.sv
  - target: test
    files:
      - box_overlay_tb.sv

/* box_if.sv */
`timescale 1ns/10ps

interface box_if import box_overlay_pkg::*; ();

    // Committed descriptors, index 0 has lowest priority.
    box_t [N_BOX-1:0] boxes;

    modport source (
        output boxes
    );

    modport sink (
        input boxes
    );

endinterface

/* box_overlay.sv */
`timescale 1ns/10ps

module box_overlay import box_overlay_pkg::*; (
    input  logic   pix_clk,
    input  logic   i_rst_n,
    video_if.sink  i_vid,
    box_if.sink    i_boxes,
    output logic   o_vid_hsync,
    output logic   o_vid_vsync,
    output logic   o_vid_de,
    output rgb_t   o_vid_rgb
);

    logic [H_CNT_W-1:0] h_q;
    logic [H_CNT_W-1:0] h_pos;
    logic [V_CNT_W-1:0] v_q;
    logic [V_CNT_W-1:0] v_pos;
    logic [H_CNT_W-1:0] h_act;
    logic [V_CNT_W-1:0] v_act;
    logic [X_W-1:0]     x;
    logic [Y_W-1:0]     y;
    logic [N_BOX-1:0]   hit;
    rgb_t               pix_next;

    // Position of the pixel now at the input.
    always_comb begin
        h_pos = i_vid.sol ? '0 : h_q + 1'b1;
        if (i_vid.sof) begin
            v_pos = '0;
        end else if (i_vid.sol) begin
            v_pos = v_q + 1'b1;
        end else begin
            v_pos = v_q;
        end
    end

    always_ff @(posedge pix_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_q <= '0;
            v_q <= '0;
        end else begin
            h_q <= h_pos;
            v_q <= v_pos;
        end
    end

    assign h_act = h_pos - H_CNT_W'(H_OFS);
    assign v_act = v_pos - V_CNT_W'(V_OFS);
    assign x     = h_act[X_W-1:0];
    assign y     = v_act[Y_W-1:0];

    for (genvar i = 0; i < N_BOX; i++) begin : g_box
        box_t b;
        logic outer;
        logic inner;

        assign b = i_boxes.boxes[i];

        assign outer = (x >= b.x0) && (x <= b.x1) && (y >= b.y0) && (y <= b.y1);
        // Interior, shrunk by the border on every side.
        assign inner = (x >= b.x0 + BORDER) && (x + BORDER <= b.x1) &&
                       (y >= b.y0 + BORDER) && (y + BORDER <= b.y1);

        assign hit[i] = b.en && outer && !inner;
    end

    // Later boxes override earlier ones.
    always_comb begin
        pix_next = i_vid.pix;
        for (int i = 0; i < N_BOX; i++) begin
            if (i_vid.de && hit[i]) begin
                pix_next = i_boxes.boxes[i].color;
            end
        end
    end

    always_ff @(posedge pix_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_vid_hsync <= 1'b0;
            o_vid_vsync <= 1'b0;
            o_vid_de    <= 1'b0;
            o_vid_rgb   <= '0;
        end else begin
            o_vid_hsync <= i_vid.hsync;
            o_vid_vsync <= i_vid.vsync;
            o_vid_de    <= i_vid.de;
            o_vid_rgb   <= pix_next;
        end
    end

    // Active video may not start inside the sync pulse.
    a_de_not_in_hsync: assert property (
        @(posedge pix_clk) disable iff (!i_rst_n)
        $rose(i_vid.de) |-> !i_vid.hsync
    );

endmodule

/* box_overlay_pkg.sv */
package box_overlay_pkg;

    // Horizontal timing in pixels, small test mode.
    localparam int H_ACT   = 32;
    localparam int H_FP    = 4;
    localparam int H_SYNC  = 4;
    localparam int H_BP    = 8;
    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;

    // Vertical timing in lines.
    localparam int V_ACT   = 12;
    localparam int V_FP    = 2;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 3;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;

    // Offset from line or frame start to the first active pixel.
    localparam int H_OFS = H_SYNC + H_BP;
    localparam int V_OFS = V_SYNC + V_BP;

    localparam int X_W     = $clog2(H_ACT);
    localparam int Y_W     = $clog2(V_ACT);
    localparam int H_CNT_W = $clog2(H_TOTAL);
    localparam int V_CNT_W = $clog2(V_TOTAL);

    localparam int BITS   = 8;
    localparam int DATA_W = 3 * BITS;

    localparam int N_BOX     = 4;
    localparam int BOX_IDX_W = (N_BOX > 1) ? $clog2(N_BOX) : 1;
    localparam int BORDER    = 1;

    typedef struct packed {
        logic [BITS-1:0] r;
        logic [BITS-1:0] g;
        logic [BITS-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic           en;
        logic [X_W-1:0] x0;
        logic [X_W-1:0] x1;
        logic [Y_W-1:0] y0;
        logic [Y_W-1:0] y1;
        rgb_t           color;
    } box_t;

    // Host write opcode, selects one descriptor field.
    typedef enum logic [2:0] {
        F_X0,
        F_Y0,
        F_X1,
        F_Y1,
        F_COLOR,
        F_EN
    } box_field_e;

    typedef enum logic [1:0] {
        PAT_SOLID,
        PAT_HRAMP,
        PAT_CHECK
    } pattern_e;

endpackage

/* box_overlay_tb.sv */
`timescale 1ns/10ps

module box_overlay_tb import box_overlay_pkg::*; ();

    localparam int NUM_ROWS  = 6;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int LIMIT_CYC = NUM_ROWS * 3 * FRAME_CYC + 1000;
    localparam int MID_DELAY = H_TOTAL * 8;

    logic                 pix_clk;
    logic                 i_rst_n;
    pattern_e             i_pattern;
    rgb_t                 i_bg;
    logic                 i_wr;
    logic [BOX_IDX_W-1:0] i_wr_box;
    box_field_e           i_wr_field;
    logic [DATA_W-1:0]    i_wr_data;
    logic                 o_hsync;
    logic                 o_vsync;
    logic                 o_de;
    rgb_t                 o_rgb;

    // Stimulus table, one row per case.
    pattern_e         row_pat   [NUM_ROWS];
    rgb_t             row_bg    [NUM_ROWS];
    logic             row_mid   [NUM_ROWS];
    logic [N_BOX-1:0] row_wmask [NUM_ROWS];
    box_t             row_box   [NUM_ROWS][N_BOX];

    // Reference copies of the shadow and committed descriptors.
    box_t model_shadow [N_BOX];
    box_t model_active [N_BOX];

    int seed;
    int errors;
    int cycles = 0;

    box_overlay_top DUT (
        .pix_clk    (pix_clk),
        .i_rst_n    (i_rst_n),
        .i_pattern  (i_pattern),
        .i_bg       (i_bg),
        .i_wr       (i_wr),
        .i_wr_box   (i_wr_box),
        .i_wr_field (i_wr_field),
        .i_wr_data  (i_wr_data),
        .o_hsync    (o_hsync),
        .o_vsync    (o_vsync),
        .o_de       (o_de),
        .o_rgb      (o_rgb)
    );

    always #20 pix_clk = ~pix_clk;

    always @(posedge pix_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT_CYC) begin
            $display("Timeout: frame checks still running after %0d cycles", cycles);
            report_failure();
        end
    end

    task automatic report_failure();
        errors++;
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            report_failure();
        end
    endtask

    function automatic box_t make_box(input logic en, input int x0, input int y0,
                                      input int x1, input int y1, input logic [23:0] color);
        box_t b;
        b.en    = en;
        b.x0    = X_W'(x0);
        b.y0    = Y_W'(y0);
        b.x1    = X_W'(x1);
        b.y1    = Y_W'(y1);
        b.color = rgb_t'(color);
        return b;
    endfunction

    task automatic set_row(input int r, input pattern_e pat, input logic [23:0] bg,
                           input logic mid);
        row_pat[r]   = pat;
        row_bg[r]    = rgb_t'(bg);
        row_mid[r]   = mid;
        row_wmask[r] = '0;
        for (int i = 0; i < N_BOX; i++) begin
            row_box[r][i] = '0;
        end
    endtask

    task automatic set_box(input int r, input int i, input box_t b);
        row_wmask[r][i] = 1'b1;
        row_box[r][i]   = b;
    endtask

    task automatic build_table();
        // Bare patterns, nothing enabled yet.
        set_row(0, PAT_SOLID, 24'h204060, 1'b0);
        set_row(1, PAT_HRAMP, 24'h10205a, 1'b0);
        set_row(2, PAT_CHECK, 24'hc0c0c0, 1'b0);
        set_row(3, PAT_HRAMP, 24'h000033, 1'b0);
        set_box(3, 1, make_box(1'b1, 4, 2, 12, 8, 24'hff0000));
        // Box 2 overlaps box 0; box 3 is written but disabled.
        set_row(4, PAT_SOLID, 24'h404040, 1'b0);
        set_box(4, 0, make_box(1'b1, 8, 3, 20, 10, 24'h00ff00));
        set_box(4, 1, make_box(1'b0, 4, 2, 12, 8, 24'hff0000));
        set_box(4, 2, make_box(1'b1, 16, 0, H_ACT - 1, 6, 24'h0000ff));
        set_box(4, 3, make_box(1'b0, 2, 1, 28, 9, 24'hffff00));
        // Edge to edge box, written in the middle of a frame.
        set_row(5, PAT_CHECK, 24'h808080, 1'b1);
        set_box(5, 3, make_box(1'b1, 0, 0, H_ACT - 1, V_ACT - 1, 24'hff00ff));
        set_box(5, 0, make_box(1'b0, 8, 3, 20, 10, 24'h00ff00));
    endtask

    function automatic logic [DATA_W-1:0] field_data(input box_t b, input box_field_e field);
        case (field)
            F_X0:    return DATA_W'(b.x0);
            F_Y0:    return DATA_W'(b.y0);
            F_X1:    return DATA_W'(b.x1);
            F_Y1:    return DATA_W'(b.y1);
            F_COLOR: return DATA_W'(b.color);
            default: return DATA_W'(b.en);
        endcase
    endfunction

    task automatic host_write(input int idx, input box_field_e field,
                              input logic [DATA_W-1:0] data);
        @(posedge pix_clk);
        #2;
        i_wr       = 1'b1;
        i_wr_box   = BOX_IDX_W'(idx);
        i_wr_field = field;
        i_wr_data  = data;
        @(posedge pix_clk);
        #2;
        i_wr = 1'b0;
    endtask

    task automatic write_box(input int idx, input box_t b);
        for (int f = 0; f < 6; f++) begin
            host_write(idx, box_field_e'(f), field_data(b, box_field_e'(f)));
        end
        model_shadow[idx] = b;
    endtask

    task automatic apply_row_writes(input int r);
        for (int i = 0; i < N_BOX; i++) begin
            if (row_wmask[r][i]) begin
                write_box(i, row_box[r][i]);
            end
        end
    endtask

    // Junk write, then the old value again before any frame start.
    task automatic scribble_random();
        int         idx;
        box_field_e field;
        idx   = $unsigned($random(seed)) % N_BOX;
        field = box_field_e'($unsigned($random(seed)) % 6);
        host_write(idx, field, DATA_W'($random(seed)));
        host_write(idx, field, field_data(model_shadow[idx], field));
    endtask

    function automatic rgb_t expected_pixel(input pattern_e pat, input rgb_t bg,
                                            input int x, input int y);
        rgb_t p;
        box_t b;
        int   x0;
        int   x1;
        int   y0;
        int   y1;
        logic in_outer;
        logic in_inner;
        case (pat)
            PAT_HRAMP: begin
                p.r = BITS'(x * 8);
                p.g = BITS'(y * 16);
                p.b = bg.b;
            end
            PAT_CHECK: begin
                p = (((x ^ y) & 4) != 0) ? bg : '0;
            end
            default: begin
                p = bg;
            end
        endcase
        // Ascending order, so the highest index wins.
        for (int i = 0; i < N_BOX; i++) begin
            b  = model_active[i];
            x0 = int'(b.x0);
            x1 = int'(b.x1);
            y0 = int'(b.y0);
            y1 = int'(b.y1);
            in_outer = (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
            in_inner = (x >= x0 + BORDER) && (x <= x1 - BORDER) &&
                       (y >= y0 + BORDER) && (y <= y1 - BORDER);
            if (b.en && in_outer && !in_inner) begin
                p = b.color;
            end
        end
        return p;
    endfunction

    task automatic wait_frame_start();
        logic prev;
        logic found;
        prev  = o_vsync;
        found = 1'b0;
        while (!found) begin
            @(negedge pix_clk);
            found = o_vsync && !prev;
            prev  = o_vsync;
        end
    endtask

    // Starts on the sample where o_vsync has just risen.
    task automatic check_frame(input int r);
        int   x;
        int   lines;
        logic de_exp;
        lines = 0;
        for (int v = 0; v < V_TOTAL; v++) begin
            x = 0;
            for (int h = 0; h < H_TOTAL; h++) begin
                if (v != 0 || h != 0) begin
                    @(negedge pix_clk);
                end
                de_exp = (h >= H_OFS) && (h < H_OFS + H_ACT) &&
                         (v >= V_OFS) && (v < V_OFS + V_ACT);
                check_bit("o_hsync", o_hsync, h < H_SYNC);
                check_bit("o_vsync", o_vsync, v < V_SYNC);
                check_bit("o_de", o_de, de_exp);
                if (o_de) begin
                    check_rgb($sformatf("o_rgb at x=%0d y=%0d", x, lines), o_rgb,
                              expected_pixel(row_pat[r], row_bg[r], x, lines));
                    x++;
                end else begin
                    // Blanking stays black.
                    check_rgb("o_rgb in blanking", o_rgb, '0);
                end
            end
            if (x != 0) begin
                check_count("de cycles per line", x, H_ACT);
                lines++;
            end
        end
        check_count("active lines per frame", lines, V_ACT);
    endtask

    initial begin
        pix_clk    = 1'b0;
        i_rst_n    = 1'b0;
        i_pattern  = PAT_SOLID;
        i_bg       = '0;
        i_wr       = 1'b0;
        i_wr_box   = '0;
        i_wr_field = F_X0;
        i_wr_data  = '0;
        seed       = 39;
        errors     = 0;
        for (int i = 0; i < N_BOX; i++) begin
            model_shadow[i] = '0;
            model_active[i] = '0;
        end
        build_table();
        repeat (9) @(posedge pix_clk);
        @(negedge pix_clk);
        check_bit("o_hsync", o_hsync, 1'b0);
        check_bit("o_vsync", o_vsync, 1'b0);
        check_bit("o_de", o_de, 1'b0);
        check_rgb("o_rgb", o_rgb, '0);
        @(posedge pix_clk);
        #2;
        i_rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge pix_clk);
            #2;
            i_pattern = row_pat[r];
            i_bg      = row_bg[r];
            scribble_random();
            if (!row_mid[r]) begin
                apply_row_writes(r);
            end
            wait_frame_start();
            wait_frame_start();
            model_active = model_shadow;
            if (row_mid[r]) begin
                // Writes land mid-frame and must wait for the next one.
                fork
                    check_frame(r);
                    begin
                        repeat (MID_DELAY) @(posedge pix_clk);
                        apply_row_writes(r);
                    end
                join
                wait_frame_start();
                model_active = model_shadow;
            end
            check_frame(r);
        end

        if (errors == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

/* box_overlay_top.sv */
`timescale 1ns/10ps

module box_overlay_top import box_overlay_pkg::*; (
    input  logic                 pix_clk,
    input  logic                 i_rst_n,
    input  pattern_e             i_pattern,
    input  rgb_t                 i_bg,
    input  logic                 i_wr,
    input  logic [BOX_IDX_W-1:0] i_wr_box,
    input  box_field_e           i_wr_field,
    input  logic [DATA_W-1:0]    i_wr_data,
    output logic                 o_hsync,
    output logic                 o_vsync,
    output logic                 o_de,
    output rgb_t                 o_rgb
);

    video_if vid ();
    box_if   boxes ();

    // Pattern source and timing.
    video_timing_gen u_gen (
        .pix_clk   (pix_clk),
        .i_rst_n   (i_rst_n),
        .i_pattern (i_pattern),
        .i_bg      (i_bg),
        .o_vid     (vid)
    );

    // Host descriptors, committed at each frame start.
    box_table u_table (
        .pix_clk    (pix_clk),
        .i_rst_n    (i_rst_n),
        .i_wr       (i_wr),
        .i_wr_box   (i_wr_box),
        .i_wr_field (i_wr_field),
        .i_wr_data  (i_wr_data),
        .tbl        (vid),
        .o_boxes    (boxes)
    );

    box_overlay u_overlay (
        .pix_clk     (pix_clk),
        .i_rst_n     (i_rst_n),
        .i_vid       (vid),
        .i_boxes     (boxes),
        .o_vid_hsync (o_hsync),
        .o_vid_vsync (o_vsync),
        .o_vid_de    (o_de),
        .o_vid_rgb   (o_rgb)
    );

endmodule

/* box_table.sv */
`timescale 1ns/10ps

module box_table import box_overlay_pkg::*; (
    input  logic                 pix_clk,
    input  logic                 i_rst_n,
    input  logic                 i_wr,
    input  logic [BOX_IDX_W-1:0] i_wr_box,
    input  box_field_e           i_wr_field,
    input  logic [DATA_W-1:0]    i_wr_data,
    video_if.table_side          tbl,
    box_if.source                o_boxes
);

    box_t [N_BOX-1:0] shadow;
    box_t [N_BOX-1:0] active;

    // Host side, one field per write.
    always_ff @(posedge pix_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shadow <= '0;
        end else if (i_wr) begin
            case (i_wr_field)
                F_X0: begin
                    shadow[i_wr_box].x0 <= i_wr_data[X_W-1:0];
                end
                F_Y0: begin
                    shadow[i_wr_box].y0 <= i_wr_data[Y_W-1:0];
                end
                F_X1: begin
                    shadow[i_wr_box].x1 <= i_wr_data[X_W-1:0];
                end
                F_Y1: begin
                    shadow[i_wr_box].y1 <= i_wr_data[Y_W-1:0];
                end
                F_COLOR: begin
                    shadow[i_wr_box].color <= rgb_t'(i_wr_data);
                end
                F_EN: begin
                    shadow[i_wr_box].en <= i_wr_data[0];
                end
                default: begin
                end
            endcase
        end
    end

    // Whole set moves at once, so a frame never sees half an update.
    always_ff @(posedge pix_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active <= '0;
        end else if (tbl.sof) begin
            active <= shadow;
        end
    end

    assign o_boxes.boxes = active;

    // Host must name an existing box and a known field.
    a_wr_box_range: assert property (
        @(posedge pix_clk) disable iff (!i_rst_n)
        i_wr |-> (int'(i_wr_box) < N_BOX) && (i_wr_field <= F_EN)
    );

endmodule

/* files.f */
box_overlay_pkg.sv
video_if.sv
box_if.sv
video_timing_gen.sv
box_table.sv
box_overlay.sv
box_overlay_top.sv
box_overlay_tb.sv

/* video_if.sv */
`timescale 1ns/10ps

interface video_if import box_overlay_pkg::*; ();

    logic hsync;
    logic vsync;
    logic de;
    logic sol;
    logic sof;
    rgb_t pix;

    // Timing generator side.
    modport source (
        output hsync,
        output vsync,
        output de,
        output sol,
        output sof,
        output pix
    );

    // Descriptor table only needs the frame strobe.
    modport table_side (
        input sof
    );

    modport sink (
        input hsync,
        input vsync,
        input de,
        input sol,
        input sof,
        input pix
    );

endinterface

/* video_timing_gen.sv */
`timescale 1ns/10ps

module video_timing_gen import box_overlay_pkg::*; (
    input  logic           pix_clk,
    input  logic           i_rst_n,
    input  pattern_e       i_pattern,
    input  rgb_t           i_bg,
    video_if.source        o_vid
);

    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;
    logic [H_CNT_W-1:0] h_act;
    logic [V_CNT_W-1:0] v_act;
    logic [X_W-1:0]     x;
    logic [Y_W-1:0]     y;
    logic               h_de;
    logic               v_de;
    logic               de_c;
    rgb_t               pat;

    // Line runs sync, back porch, active, front porch.
    always_ff @(posedge pix_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_CNT_W'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == V_CNT_W'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_act = h_cnt - H_CNT_W'(H_OFS);
    assign v_act = v_cnt - V_CNT_W'(V_OFS);
    assign x     = h_act[X_W-1:0];
    assign y     = v_act[Y_W-1:0];

    assign h_de = (h_cnt >= H_CNT_W'(H_OFS)) && (h_cnt < H_CNT_W'(H_OFS + H_ACT));
    assign v_de = (v_cnt >= V_CNT_W'(V_OFS)) && (v_cnt < V_CNT_W'(V_OFS + V_ACT));
    assign de_c = h_de && v_de;

    always_comb begin
        case (i_pattern)
            PAT_SOLID: begin
                pat = i_bg;
            end
            PAT_HRAMP: begin
                pat.r = BITS'({x, 3'b000});
                pat.g = BITS'({y, 4'b0000});
                pat.b = i_bg.b;
            end
            PAT_CHECK: begin
                // Squares of 4 by 4 pixels.
                pat = (x[2] ^ y[2]) ? i_bg : '0;
            end
            default: begin
                pat = '0;
            end
        endcase
    end

    always_ff @(posedge pix_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_vid.hsync <= 1'b0;
            o_vid.vsync <= 1'b0;
            o_vid.de    <= 1'b0;
            o_vid.sol   <= 1'b0;
            o_vid.sof   <= 1'b0;
            o_vid.pix   <= '0;
        end else begin
            o_vid.hsync <= (h_cnt < H_CNT_W'(H_SYNC));
            o_vid.vsync <= (v_cnt < V_CNT_W'(V_SYNC));
            o_vid.de    <= de_c;
            o_vid.sol   <= (h_cnt == '0);
            o_vid.sof   <= (h_cnt == '0) && (v_cnt == '0);
            o_vid.pix   <= de_c ? pat : '0;
        end
    end

    // Frame start sits on a line start, at the rise of vsync.
    a_sof_on_sol: assert property (
        @(posedge pix_clk) disable iff (!i_rst_n)
        o_vid.sof |-> o_vid.sol && o_vid.vsync && !$past(o_vid.vsync)
    );

endmodule
